// ==== dcache_bus_pkg.sv ====
//****************************************************************************
// Data cache bus structures
// CPU request and response, refill beat from memory and the
// write-through request towards memory
//****************************************************************************
package dcache_bus_pkg;
   import dcache_cfg_pkg::*;

   // CPU access, sampled with the request strobe
   typedef struct packed {
      logic  we;
      bsel_t bsel;
      addr_t addr;
      data_t wdata;
   } cpu_req_t;

   // Acknowledge is a one cycle strobe
   typedef struct packed {
      logic  ack;
      data_t rdata;
   } cpu_rsp_t;

   // One word of a line refill, words arrive in order from word 0
   typedef struct packed {
      logic  valid;
      data_t data;
   } refill_t;

   // Write-through request, one cycle valid and no back-pressure
   typedef struct packed {
      logic  valid;
      addr_t addr;
      bsel_t bsel;
      data_t data;
   } mem_wr_t;

endpackage

// ==== dcache_cfg_pkg.sv ====
//****************************************************************************
// Data cache configuration
// Word, address and byte-lane types shared by every cache block
// Way count is fixed at two for the pseudo-LRU history
//****************************************************************************
package dcache_cfg_pkg;

   // CPU word and byte address widths
   localparam int DATA_W = 32;
   localparam int ADDR_W = 32;
   // One enable per byte of the word
   localparam int BSEL_W = DATA_W / 8;
   // Two ways, one history bit per set
   localparam int NUM_WAYS = 2;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [BSEL_W-1:0] bsel_t;

   // One-hot way vector for hits, victims and write enables
   typedef logic [NUM_WAYS-1:0] way_t;

endpackage

// ==== dcache_ctrl.sv ====
//****************************************************************************
// Data cache controller
// Sequences lookup, line refill on read miss, write-through and
// set invalidate. One CPU request is in flight at a time
//****************************************************************************
`timescale 1ns/1ns

module dcache_ctrl
   import dcache_cfg_pkg::*;
   import dcache_bus_pkg::*;
#(
   parameter int  SET_W   = 4,
   parameter int  BLOCK_W = 4,
   localparam int WORD_W  = BLOCK_W - 2,
   localparam int RAM_AW  = SET_W + WORD_W,
   localparam int TAG_W   = ADDR_W - SET_W - BLOCK_W
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              req_valid_i,
   input  cpu_req_t          req_i,
   input  logic              inv_i,
   input  addr_t             inv_adr_i,
   input  refill_t           refill_i,
   input  way_t              hit_i,
   input  way_t              victim_i,
   input  data_t             rdata_i,
   output cpu_rsp_t          rsp_o,
   output logic              refill_req_o,
   output addr_t             refill_adr_o,
   output mem_wr_t           mem_wr_o,
   output logic [RAM_AW-1:0] rd_addr_o,
   output logic [RAM_AW-1:0] wr_addr_o,
   output logic [TAG_W-1:0]  tag_o,
   output logic              tag_we_o,
   output logic              valid_set_o,
   output logic              inv_o,
   output logic              lru_update_o,
   output way_t              access_o,
   output way_t              way_we_o,
   output data_t             way_wdata_o,
   output bsel_t             way_bsel_o,
   output logic              merge_o
);

   typedef enum logic [1:0] {IDLE, LOOKUP, REFILL} state_t;

   state_t            state_q;
   cpu_req_t          req_q;
   way_t              victim_q;
   logic [WORD_W-1:0] beat_q;
   logic [SET_W-1:0]  inv_set_q;
   logic              inv_q;
   logic              ack_q;
   data_t             word_q;
   logic [RAM_AW-1:0] req_word;
   logic              hit;
   logic              miss;

   assign req_word = req_q.addr[BLOCK_W+SET_W-1:2];
   assign hit      = |hit_i;
   // Reads only, a write miss does not allocate
   assign miss     = (state_q == LOOKUP) && !req_q.we && !hit;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= IDLE;
         beat_q  <= '0;
         inv_q   <= 1'b0;
         ack_q   <= 1'b0;
      end else begin
         inv_q <= inv_i;
         ack_q <= 1'b0;
         case (state_q)
            IDLE: begin
               if (req_valid_i) begin
                  state_q <= LOOKUP;
               end
            end
            LOOKUP: begin
               state_q <= miss ? REFILL : IDLE;
            end
            REFILL: begin
               // Counter wraps to zero on the last beat
               if (refill_i.valid) begin
                  beat_q <= beat_q + 1'b1;
                  if (&beat_q) begin
                     state_q <= IDLE;
                     ack_q   <= 1'b1;
                  end
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == IDLE && req_valid_i) begin
         req_q <= req_i;
      end
      if (inv_i) begin
         inv_set_q <= inv_adr_i[BLOCK_W +: SET_W];
      end
      if (state_q == LOOKUP) begin
         victim_q <= victim_i;
      end
      // Keep the word the CPU asked for while the line streams in
      if (state_q == REFILL && refill_i.valid && beat_q == req_q.addr[BLOCK_W-1:2]) begin
         word_q <= refill_i.data;
      end
   end

   always_comb begin
      tag_we_o     = 1'b0;
      valid_set_o  = 1'b0;
      lru_update_o = 1'b0;
      access_o     = '0;
      way_we_o     = '0;
      merge_o      = 1'b0;
      way_wdata_o  = req_q.wdata;
      wr_addr_o    = req_word;
      case (state_q)
         LOOKUP: begin
            if (hit) begin
               lru_update_o = 1'b1;
               access_o     = hit_i;
               // Write hit updates the line in place
               if (req_q.we) begin
                  way_we_o = hit_i;
                  merge_o  = 1'b1;
               end
            end
         end
         REFILL: begin
            if (refill_i.valid) begin
               way_we_o    = victim_q;
               way_wdata_o = refill_i.data;
               wr_addr_o   = {req_word[RAM_AW-1:WORD_W], beat_q};
               // Line complete, install tag and mark it used
               if (&beat_q) begin
                  tag_we_o     = 1'b1;
                  valid_set_o  = 1'b1;
                  lru_update_o = 1'b1;
                  access_o     = victim_q;
               end
            end
         end
         default: ;
      endcase
      if (inv_q) begin
         wr_addr_o = {inv_set_q, {WORD_W{1'b0}}};
      end
   end

   // RAMs read the new request in its strobe cycle
   assign rd_addr_o    = (state_q == IDLE) ? req_i.addr[BLOCK_W+SET_W-1:2] : req_word;
   assign tag_o        = req_q.addr[ADDR_W-1 -: TAG_W];
   assign inv_o        = inv_q;
   assign way_bsel_o   = req_q.bsel;
   assign refill_req_o = miss || (state_q == REFILL);
   assign refill_adr_o = {req_q.addr[ADDR_W-1:BLOCK_W], {BLOCK_W{1'b0}}};

   assign rsp_o = '{ack:   ack_q || (state_q == LOOKUP && (req_q.we || hit)),
                    rdata: ack_q ? word_q : rdata_i};

   // Every write goes to memory in the lookup cycle
   assign mem_wr_o = '{valid: (state_q == LOOKUP) && req_q.we,
                       addr:  req_q.addr,
                       bsel:  req_q.bsel,
                       data:  req_q.wdata};

   // CPU waits for the acknowledge before the next strobe
   assert property (@(posedge clk) disable iff (rst) req_valid_i |-> state_q == IDLE);
   assert property (@(posedge clk) disable iff (rst) !(rsp_o.ack && refill_req_o));

endmodule

// ==== dcache_lru.sv ====
//****************************************************************************
// Pseudo-LRU history for a two-way set
// History bit is the most recently used way
// Victim is the way that was not used last
//****************************************************************************
`timescale 1ns/1ns

module dcache_lru
   import dcache_cfg_pkg::*;
(
   input  logic history_i,
   input  way_t access_i,
   output logic history_o,
   output way_t victim_o
);

   // Update on access, keep the history otherwise
   always_comb begin
      history_o = history_i;
      if (access_i[1]) begin
         history_o = 1'b1;
      end else if (access_i[0]) begin
         history_o = 1'b0;
      end
   end

   // Way 1 used last means way 0 goes next and vice versa
   assign victim_o = {~history_i, history_i};

endmodule

// ==== dcache_sdp_ram.sv ====
//****************************************************************************
// Simple dual-port RAM
// One write port and one synchronous read port on a single clock
// A read colliding with a write returns the old word
//****************************************************************************
`timescale 1ns/1ns

module dcache_sdp_ram #(
   parameter int ADDR_BITS = 4,
   parameter int DATA_BITS = 32
) (
   input  logic                 clk,
   input  logic [ADDR_BITS-1:0] raddr_i,
   input  logic [ADDR_BITS-1:0] waddr_i,
   input  logic                 we_i,
   input  logic [DATA_BITS-1:0] din_i,
   output logic [DATA_BITS-1:0] dout_o
);

   logic [DATA_BITS-1:0] mem [2**ADDR_BITS];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
      // Registered read, contents from before this edge
      dout_o <= mem[raddr_i];
   end

endmodule

// ==== dcache_tag_store.sv ====
//****************************************************************************
// Tag store of the data cache
// Per-way tag RAMs, valid bits and LRU history in flops per set
// Compares the stored tags against the request and names the victim
//****************************************************************************
`timescale 1ns/1ns

module dcache_tag_store
   import dcache_cfg_pkg::*;
#(
   parameter int  SET_W   = 4,
   parameter int  BLOCK_W = 4,
   localparam int TAG_W   = ADDR_W - SET_W - BLOCK_W
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [SET_W-1:0] rd_index_i,
   input  logic [TAG_W-1:0] tag_i,
   input  logic [SET_W-1:0] wr_index_i,
   input  logic             tag_we_i,
   input  way_t             way_sel_i,
   input  logic             valid_set_i,
   input  logic             inv_i,
   input  logic             lru_update_i,
   input  way_t             access_i,
   output way_t             hit_o,
   output way_t             victim_o
);

   localparam int NUM_SETS = 2**SET_W;

   logic [TAG_W-1:0]    tag_rd [NUM_WAYS];
   way_t [NUM_SETS-1:0] valid_q;
   logic [NUM_SETS-1:0] lru_q;
   // Lines the flop lookups up with the RAM output
   logic [SET_W-1:0]    rd_index_q;
   logic                lru_next;

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      dcache_sdp_ram #(.ADDR_BITS(SET_W), .DATA_BITS(TAG_W)) u_tag_ram (
         .clk     (clk),
         .raddr_i (rd_index_i),
         .waddr_i (wr_index_i),
         .we_i    (tag_we_i & way_sel_i[w]),
         .din_i   (tag_i),
         .dout_o  (tag_rd[w])
      );
      // Valid entry with matching tag
      assign hit_o[w] = valid_q[rd_index_q][w] && (tag_rd[w] == tag_i);
   end

   // History of the set being written, also used for the victim
   dcache_lru u_lru (
      .history_i (lru_q[wr_index_i]),
      .access_i  (access_i),
      .history_o (lru_next),
      .victim_o  (victim_o)
   );

   always_ff @(posedge clk) begin
      rd_index_q <= rd_index_i;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
         lru_q   <= '0;
      end else if (inv_i) begin
         // Drop every way of the set
         valid_q[wr_index_i] <= '0;
         lru_q[wr_index_i]   <= 1'b0;
      end else begin
         if (valid_set_i) begin
            valid_q[wr_index_i] <= valid_q[wr_index_i] | way_sel_i;
         end
         if (lru_update_i) begin
            lru_q[wr_index_i] <= lru_next;
         end
      end
   end

   // Refill only on a miss, so one tag is never valid in both ways
   assert property (@(posedge clk) disable iff (rst) $onehot0(hit_o));

endmodule

// ==== dcache_top.sv ====
//****************************************************************************
// Two-way set-associative write-through data cache
// Joins the controller, the tag store and the way data RAMs
//****************************************************************************
`timescale 1ns/1ns

module dcache_top
   import dcache_cfg_pkg::*;
   import dcache_bus_pkg::*;
#(
   parameter int  SET_W   = 4,
   parameter int  BLOCK_W = 4,
   localparam int RAM_AW  = SET_W + BLOCK_W - 2,
   localparam int TAG_W   = ADDR_W - SET_W - BLOCK_W
) (
   input  logic     clk,
   input  logic     rst,
   input  cpu_req_t req_i,
   input  logic     req_valid_i,
   output cpu_rsp_t rsp_o,
   output logic     refill_req_o,
   output addr_t    refill_adr_o,
   input  refill_t  refill_i,
   output mem_wr_t  mem_wr_o,
   input  logic     inv_i,
   input  addr_t    inv_adr_i
);

   logic [RAM_AW-1:0] rd_addr;
   logic [RAM_AW-1:0] wr_addr;
   logic [TAG_W-1:0]  tag;
   logic              tag_we;
   logic              valid_set;
   logic              inv;
   logic              lru_update;
   way_t              access;
   way_t              way_we;
   way_t              hit;
   way_t              victim;
   data_t             way_wdata;
   data_t             rdata;
   bsel_t             way_bsel;
   logic              merge;

   dcache_ctrl #(.SET_W(SET_W), .BLOCK_W(BLOCK_W)) u_ctrl (
      .clk          (clk),
      .rst          (rst),
      .req_valid_i  (req_valid_i),
      .req_i        (req_i),
      .inv_i        (inv_i),
      .inv_adr_i    (inv_adr_i),
      .refill_i     (refill_i),
      .hit_i        (hit),
      .victim_i     (victim),
      .rdata_i      (rdata),
      .rsp_o        (rsp_o),
      .refill_req_o (refill_req_o),
      .refill_adr_o (refill_adr_o),
      .mem_wr_o     (mem_wr_o),
      .rd_addr_o    (rd_addr),
      .wr_addr_o    (wr_addr),
      .tag_o        (tag),
      .tag_we_o     (tag_we),
      .valid_set_o  (valid_set),
      .inv_o        (inv),
      .lru_update_o (lru_update),
      .access_o     (access),
      .way_we_o     (way_we),
      .way_wdata_o  (way_wdata),
      .way_bsel_o   (way_bsel),
      .merge_o      (merge)
   );

   // Tag store sees only the set index part of the word addresses
   dcache_tag_store #(.SET_W(SET_W), .BLOCK_W(BLOCK_W)) u_tag_store (
      .clk          (clk),
      .rst          (rst),
      .rd_index_i   (rd_addr[RAM_AW-1 -: SET_W]),
      .tag_i        (tag),
      .wr_index_i   (wr_addr[RAM_AW-1 -: SET_W]),
      .tag_we_i     (tag_we),
      .way_sel_i    (access),
      .valid_set_i  (valid_set),
      .inv_i        (inv),
      .lru_update_i (lru_update),
      .access_i     (access),
      .hit_o        (hit),
      .victim_o     (victim)
   );

   dcache_way_data #(.SET_W(SET_W), .BLOCK_W(BLOCK_W)) u_way_data (
      .clk       (clk),
      .rd_word_i (rd_addr),
      .wr_word_i (wr_addr),
      .way_we_i  (way_we),
      .wdata_i   (way_wdata),
      .bsel_i    (way_bsel),
      .merge_i   (merge),
      .hit_i     (hit),
      .rdata_o   (rdata)
   );

endmodule

// ==== dcache_way_data.sv ====
//****************************************************************************
// Way data of the data cache
// One data RAM per way, read word picked by the hit vector
// Write hits merge byte lanes into the stored word
//****************************************************************************
`timescale 1ns/1ns

module dcache_way_data
   import dcache_cfg_pkg::*;
#(
   parameter int  SET_W   = 4,
   parameter int  BLOCK_W = 4,
   // Set index plus word in line
   localparam int RAM_AW  = SET_W + BLOCK_W - 2
) (
   input  logic              clk,
   input  logic [RAM_AW-1:0] rd_word_i,
   input  logic [RAM_AW-1:0] wr_word_i,
   input  way_t              way_we_i,
   input  data_t             wdata_i,
   input  bsel_t             bsel_i,
   input  logic              merge_i,
   input  way_t              hit_i,
   output data_t             rdata_o
);

   data_t way_rd [NUM_WAYS];
   data_t din;

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      dcache_sdp_ram #(.ADDR_BITS(RAM_AW), .DATA_BITS(DATA_W)) u_data_ram (
         .clk     (clk),
         .raddr_i (rd_word_i),
         .waddr_i (wr_word_i),
         .we_i    (way_we_i[w]),
         .din_i   (din),
         .dout_o  (way_rd[w])
      );
   end

   // Hit vector is one-hot, so an OR of the masked words is enough
   always_comb begin
      rdata_o = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (hit_i[w]) begin
            rdata_o = rdata_o | way_rd[w];
         end
      end
   end

   // Keep the stored bytes where the CPU does not write
   always_comb begin
      din = wdata_i;
      if (merge_i) begin
         for (int b = 0; b < BSEL_W; b++) begin
            if (!bsel_i[b]) begin
               din[8*b +: 8] = rdata_o[8*b +: 8];
            end
         end
      end
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_dcache \
   -f sources.f -o tb_dcache_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/tb_dcache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
   echo "Simulation failed"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
echo "Simulation passed"
exit 0

// ==== sources.f ====
+incdir+.
dcache_cfg_pkg.sv
dcache_bus_pkg.sv
dcache_sdp_ram.sv
dcache_lru.sv
dcache_tag_store.sv
dcache_way_data.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv

// ==== tb_dcache_table.svh ====
//****************************************************************************
// Stimulus table of the data cache testbench
// One row per operation, with the refill that the row should cause
//****************************************************************************
`ifndef TB_DCACHE_TABLE_SVH
`define TB_DCACHE_TABLE_SVH

localparam logic [1:0] OP_RD  = 2'd0;
localparam logic [1:0] OP_WR  = 2'd1;
localparam logic [1:0] OP_INV = 2'd2;

typedef struct packed {
   logic [1:0] op;
   addr_t      addr;
   data_t      wdata;
   bsel_t      bsel;
   logic       miss;
} row_t;

localparam int NUM_ROWS = 16;

// Columns: operation, byte address, write data, byte enables, refill expected
// Lines 0x1030, 0x2030 and 0x3030 all fall in set 3
localparam row_t ROWS [NUM_ROWS] = '{
   '{OP_RD,  32'h0000_0148, 32'h0000_0000, 4'b0000, 1'b1},
   '{OP_RD,  32'h0000_0148, 32'h0000_0000, 4'b0000, 1'b0},
   '{OP_RD,  32'h0000_0144, 32'h0000_0000, 4'b0000, 1'b0},
   '{OP_WR,  32'h0000_0148, 32'ha5a5_5a5a, 4'b0110, 1'b0},
   '{OP_RD,  32'h0000_0148, 32'h0000_0000, 4'b0000, 1'b0},
   '{OP_WR,  32'h0000_0500, 32'h1234_5678, 4'b0011, 1'b0},
   '{OP_RD,  32'h0000_0500, 32'h0000_0000, 4'b0000, 1'b1},
   '{OP_RD,  32'h0000_1030, 32'h0000_0000, 4'b0000, 1'b1},
   '{OP_RD,  32'h0000_2034, 32'h0000_0000, 4'b0000, 1'b1},
   '{OP_RD,  32'h0000_1038, 32'h0000_0000, 4'b0000, 1'b0},
   '{OP_RD,  32'h0000_303c, 32'h0000_0000, 4'b0000, 1'b1},
   '{OP_RD,  32'h0000_1030, 32'h0000_0000, 4'b0000, 1'b0},
   '{OP_RD,  32'h0000_2030, 32'h0000_0000, 4'b0000, 1'b1},
   '{OP_INV, 32'h0000_0140, 32'h0000_0000, 4'b0000, 1'b0},
   '{OP_RD,  32'h0000_0148, 32'h0000_0000, 4'b0000, 1'b1},
   '{OP_RD,  32'h0000_014c, 32'h0000_0000, 4'b0000, 1'b0}
};

`endif

// ==== tb_dcache.sv ====
//****************************************************************************
// Testbench of the two-way write-through data cache
// Memory model with random refill gaps, table driven accesses,
// latency, refill and write-through checks
//****************************************************************************
`timescale 1ns/1ns

module tb_dcache
   import dcache_cfg_pkg::*;
   import dcache_bus_pkg::*;
();

   localparam int SET_W      = 4;
   localparam int BLOCK_W    = 4;
   localparam int LINE_WORDS = 2**(BLOCK_W-2);
   localparam int TIMEOUT    = 200;

   `include "tb_dcache_table.svh"

   logic     clk        = 1'b0;
   logic     rst        = 1'b1;
   cpu_req_t req        = '0;
   logic     req_valid  = 1'b0;
   refill_t  refill     = '0;
   logic     inv        = 1'b0;
   addr_t    inv_adr    = '0;
   cpu_rsp_t rsp;
   logic     refill_req;
   addr_t    refill_adr;
   mem_wr_t  mem_wr;

   integer   seed       = 32'hf8fe;
   data_t    salt       = '0;
   int       beats_sent = 0;
   // Memory as written over the bus and as predicted from the table
   data_t    mem_model [addr_t];
   data_t    ref_mem [addr_t];

   always #20 clk = ~clk;

   dcache_top #(.SET_W(SET_W), .BLOCK_W(BLOCK_W)) u_dcache_top (
      .clk          (clk),
      .rst          (rst),
      .req_i        (req),
      .req_valid_i  (req_valid),
      .rsp_o        (rsp),
      .refill_req_o (refill_req),
      .refill_adr_o (refill_adr),
      .refill_i     (refill),
      .mem_wr_o     (mem_wr),
      .inv_i        (inv),
      .inv_adr_i    (inv_adr)
   );

   // Initial word contents depend on every address bit
   function automatic data_t fill_word(input addr_t a);
      return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ salt;
   endfunction

   function automatic data_t merge_bytes(input data_t old_w, input data_t new_w,
                                         input bsel_t be);
      data_t w;
      w = old_w;
      for (int b = 0; b < BSEL_W; b++) begin
         if (be[b]) begin
            w[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return w;
   endfunction

   function automatic data_t model_word(input addr_t a);
      addr_t wa;
      wa = {a[ADDR_W-1:2], 2'b00};
      if (mem_model.exists(wa)) begin
         return mem_model[wa];
      end
      return fill_word(wa);
   endfunction

   function automatic data_t expected_word(input addr_t a);
      addr_t wa;
      wa = {a[ADDR_W-1:2], 2'b00};
      if (ref_mem.exists(wa)) begin
         return ref_mem[wa];
      end
      return fill_word(wa);
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         stop_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
      end
   endtask

   // Memory model
   // Beats follow the request in word order with random idle cycles
   always @(posedge clk) begin
      refill <= '0;
      if (!refill_req) begin
         beats_sent <= 0;
      end else if (beats_sent < LINE_WORDS && ($random(seed) & 1) == 1) begin
         refill     <= '{valid: 1'b1,
                         data:  model_word(refill_adr + addr_t'(4 * beats_sent))};
         beats_sent <= beats_sent + 1;
      end
      // Write-through lands byte lane by byte lane
      if (mem_wr.valid) begin
         mem_model[{mem_wr.addr[ADDR_W-1:2], 2'b00}] =
            merge_bytes(model_word(mem_wr.addr), mem_wr.data, mem_wr.bsel);
      end
   end

   // Strobe one read or write and wait for the acknowledge
   task automatic run_access(input row_t row, input int idx);
      int cycles;
      int first_refill;
      int beats;
      int last_beat;
      cycles       = 0;
      first_refill = 0;
      beats        = 0;
      last_beat    = 0;
      @(posedge clk);
      req_valid <= 1'b1;
      req       <= '{we: row.op == OP_WR, bsel: row.bsel, addr: row.addr, wdata: row.wdata};
      if (row.op == OP_WR) begin
         ref_mem[{row.addr[ADDR_W-1:2], 2'b00}] =
            merge_bytes(expected_word(row.addr), row.wdata, row.bsel);
      end
      @(posedge clk);
      req_valid <= 1'b0;
      // First mid-cycle sample falls in the cycle after the strobe
      do begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) begin
            stop_run($sformatf("Timeout: row %0d got no acknowledge", idx));
         end
         check_value("mem_wr_o.valid", 32'(mem_wr.valid), 32'(row.op == OP_WR));
         if (refill_req && first_refill == 0) begin
            first_refill = cycles;
            check_value("refill_adr_o", refill_adr,
                        {row.addr[ADDR_W-1:BLOCK_W], {BLOCK_W{1'b0}}});
         end
         if (refill.valid) begin
            beats++;
            last_beat = cycles;
         end
      end while (!rsp.ack);
      check_value("refill_req_o", 32'(first_refill != 0), 32'(row.miss));
      // A miss raises the refill request in the first cycle
      // Hits and writes answer in the first cycle
      if (row.miss) begin
         check_value("refill_req_o rise cycle", 32'(first_refill), 32'd1);
         check_value("refill beats", 32'(beats), 32'(LINE_WORDS));
         // Acknowledge follows the last beat of the line
         check_value("rsp_o.ack after last beat", 32'(cycles), 32'(last_beat + 1));
      end else begin
         check_value("rsp_o.ack latency", 32'(cycles), 32'd1);
      end
      if (row.op == OP_WR) begin
         check_value("mem_wr_o.addr", mem_wr.addr, row.addr);
         check_value("mem_wr_o.data", mem_wr.data, row.wdata);
         check_value("mem_wr_o.bsel", 32'(mem_wr.bsel), 32'(row.bsel));
      end else begin
         check_value("rsp_o.rdata", rsp.rdata, expected_word(row.addr));
      end
   endtask

   task automatic run_invalidate(input row_t row);
      @(posedge clk);
      inv     <= 1'b1;
      inv_adr <= row.addr;
      @(posedge clk);
      inv <= 1'b0;
      // Valid bits drop at the end of this cycle
      @(posedge clk);
   endtask

   initial begin
      salt = $random(seed);
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_value("rsp_o.ack", 32'(rsp.ack), 32'd0);
      check_value("refill_req_o", 32'(refill_req), 32'd0);
      check_value("mem_wr_o.valid", 32'(mem_wr.valid), 32'd0);
      for (int i = 0; i < NUM_ROWS; i++) begin
         if (ROWS[i].op == OP_INV) begin
            run_invalidate(ROWS[i]);
         end else begin
            run_access(ROWS[i], i);
         end
      end
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule
